/* design/mac_frame_pkg.sv */
package mac_frame_pkg;

    typedef logic [7:0] byte_t;

    // ----------------------------------------
    // framing
    // ----------------------------------------
    localparam byte_t preamble_byte = 8'h55;
    localparam byte_t sfd_byte      = 8'hd5;
    localparam int    preamble_len  = 7;
    localparam int    fcs_len       = 4;
    localparam int    ifg_cycles    = 12;   // idle cycles between frames

    // ----------------------------------------
    // crc-32, ieee 802.3
    // ----------------------------------------
    localparam logic [31:0] crc_init    = 32'hffff_ffff;
    localparam logic [31:0] crc_poly    = 32'hedb8_8320;  // reflected polynomial
    localparam logic [31:0] crc_residue = 32'hc704_dd7b;  // msb-first form

    // one byte, lsb first on the wire
    function automatic logic [31:0] crc32_next(input logic [31:0] crc, input byte_t data);
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ crc_poly;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

/* design/mac_buffer_pkg.sv */
package mac_buffer_pkg;

    localparam int ring_depth       = 8;   // power of two, pointers wrap on their own
    localparam int max_packet_bytes = 64;
    localparam int byte_bits        = $clog2(max_packet_bytes);

    typedef logic [$clog2(ring_depth)-1:0] slot_t;
    typedef logic [$clog2(ring_depth):0]   count_t;    // 0 to ring_depth
    typedef logic [byte_bits:0]            pkt_addr_t; // 0 to 64
    typedef logic [byte_bits:0]            pkt_len_t;

    // host operations
    typedef enum logic [2:0] {
        op_read       = 3'd0,
        op_read_len   = 3'd1,
        op_read_next  = 3'd2,
        op_write      = 3'd3,
        op_write_len  = 3'd4,
        op_write_next = 3'd5
    } host_op_t;

    typedef logic [15:0] result_t;

endpackage

/* design/packet_ring.sv */
`timescale 1ns/1ps

module packet_ring
    import mac_frame_pkg::*, mac_buffer_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    // producer side
    input  logic      wr_en,
    input  pkt_addr_t wr_addr,
    input  byte_t     wr_data,
    input  logic      commit,
    input  pkt_len_t  commit_len,
    output logic      full,
    // consumer side
    input  pkt_addr_t rd_addr,
    output byte_t     rd_data,
    output pkt_len_t  rd_len,
    input  logic      release_pkt,
    output logic      empty
);

    byte_t    mem [ring_depth*max_packet_bytes];  // slot-major byte store
    pkt_len_t len [ring_depth];
    slot_t    head;     // oldest packet
    slot_t    tail;     // slot being filled
    count_t   count;

    assign full   = (count == count_t'(ring_depth));
    assign empty  = (count == '0);
    assign rd_len = len[head];

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[{tail, wr_addr[byte_bits-1:0]}] <= wr_data;
        end
        if (commit) begin
            len[tail] <= commit_len;
        end
        rd_data <= mem[{head, rd_addr[byte_bits-1:0]}];
    end

    // ----------------------------------------
    // pointers
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (commit) begin
                tail <= tail + 1'b1;
            end
            if (release_pkt) begin
                head <= head + 1'b1;
            end
            case ({commit, release_pkt})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // none, or both at once
            endcase
        end
    end

endmodule

/* design/host_ops.sv */
`timescale 1ns/1ps

module host_ops
    import mac_frame_pkg::*, mac_buffer_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      start,
    input  host_op_t  op,
    input  pkt_addr_t address,
    input  byte_t     value,
    output logic      done,
    output result_t   result,
    // transmit ring producer
    output logic      tx_wr_en,
    output pkt_addr_t tx_wr_addr,
    output byte_t     tx_wr_data,
    output logic      tx_commit,
    output pkt_len_t  tx_commit_len,
    input  logic      tx_full,
    // receive ring consumer
    output pkt_addr_t rx_rd_addr,
    input  byte_t     rx_rd_data,
    input  pkt_len_t  rx_rd_len,
    input  logic      rx_empty,
    output logic      rx_release
);

    logic      stage1;      // op latched, read address on the ring
    logic      stage2;      // ring data valid, op executes
    logic      accept;
    host_op_t  op_q;
    pkt_addr_t addr_q;
    byte_t     value_q;
    pkt_len_t  fill_len;    // highest written address plus one
    logic      addr_ok;
    result_t   result_d;

    assign accept  = start && !stage1 && !stage2;
    assign addr_ok = (addr_q < pkt_addr_t'(max_packet_bytes));

    // ring side effects land on the edge that raises done
    assign tx_wr_en      = stage2 && (op_q == op_write) && addr_ok;
    assign tx_wr_addr    = addr_q;
    assign tx_wr_data    = value_q;
    assign tx_commit     = stage2 && (op_q == op_write_next) && !tx_full;
    assign tx_commit_len = fill_len;
    assign rx_rd_addr    = addr_q;
    assign rx_release    = stage2 && (op_q == op_read_next) && !rx_empty;

    always_comb begin
        result_d = '0;
        case (op_q)
            op_read:       result_d = (!rx_empty && addr_q < rx_rd_len) ?
                                      result_t'(rx_rd_data) : '0;
            op_read_len:   result_d = rx_empty ? '0 : result_t'(rx_rd_len);
            op_read_next:  result_d = result_t'(rx_empty);
            op_write:      result_d = result_t'(!addr_ok);
            op_write_len:  result_d = result_t'(fill_len);
            op_write_next: result_d = result_t'(tx_full);
            default:       result_d = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            op_q    <= op;
            addr_q  <= address;
            value_q <= value;
        end
        if (stage2) begin
            result <= result_d;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            stage1   <= 1'b0;
            stage2   <= 1'b0;
            done     <= 1'b0;
            fill_len <= '0;
        end else begin
            stage1 <= accept;
            stage2 <= stage1;
            done   <= stage2;
            if (tx_commit) begin
                fill_len <= '0;
            end else if (tx_wr_en && addr_q >= fill_len) begin
                fill_len <= addr_q + 1'b1;
            end
        end
    end

endmodule

/* design/gmii_tx.sv */
`timescale 1ns/1ps

module gmii_tx
    import mac_frame_pkg::*, mac_buffer_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    output pkt_addr_t rd_addr,
    input  byte_t     rd_data,
    input  pkt_len_t  rd_len,
    input  logic      empty,
    output logic      release_pkt,
    output byte_t     gmii_txd,
    output logic      gmii_tx_en
);

    typedef enum logic [2:0] {
        st_idle, st_preamble, st_sfd, st_payload, st_fcs, st_gap
    } tx_state_t;

    tx_state_t   state;
    pkt_len_t    cnt;       // bytes sent in this state, or gap cycles
    pkt_len_t    len_q;
    pkt_addr_t   rd_ptr;    // one byte ahead of gmii_txd
    logic [31:0] crc;
    logic [31:0] fcs;

    assign rd_addr     = rd_ptr;
    assign fcs         = ~crc;
    assign release_pkt = (state == st_fcs) && (cnt == pkt_len_t'(fcs_len));

    always_ff @(posedge clock) begin
        if (state == st_idle) begin
            crc   <= crc_init;
            len_q <= rd_len;
        end else if ((state == st_sfd || state == st_payload) && cnt < len_q) begin
            crc <= crc32_next(crc, rd_data);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= st_idle;
            cnt        <= '0;
            rd_ptr     <= '0;
            gmii_txd   <= '0;
            gmii_tx_en <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    rd_ptr <= '0;
                    if (!empty) begin
                        state      <= st_preamble;
                        cnt        <= pkt_len_t'(1);
                        gmii_txd   <= preamble_byte;
                        gmii_tx_en <= 1'b1;
                    end
                end
                st_preamble: begin
                    if (cnt < pkt_len_t'(preamble_len)) begin
                        cnt <= cnt + 1'b1;
                    end else begin
                        state    <= st_sfd;
                        cnt      <= '0;
                        gmii_txd <= sfd_byte;
                        rd_ptr   <= rd_ptr + 1'b1;   // byte 0 already fetched
                    end
                end
                st_sfd, st_payload: begin
                    rd_ptr <= rd_ptr + 1'b1;
                    if (cnt < len_q) begin
                        state    <= st_payload;
                        cnt      <= cnt + 1'b1;
                        gmii_txd <= rd_data;
                    end else begin
                        state    <= st_fcs;
                        cnt      <= pkt_len_t'(1);
                        gmii_txd <= fcs[7:0];
                    end
                end
                st_fcs: begin
                    if (cnt < pkt_len_t'(fcs_len)) begin
                        cnt      <= cnt + 1'b1;
                        gmii_txd <= fcs[{cnt[1:0], 3'b000} +: 8];  // low byte first
                    end else begin
                        state      <= st_gap;
                        cnt        <= '0;
                        gmii_txd   <= '0;
                        gmii_tx_en <= 1'b0;
                    end
                end
                st_gap: begin
                    if (cnt == pkt_len_t'(ifg_cycles - 1)) begin
                        state <= st_idle;
                    end
                    cnt <= cnt + 1'b1;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* design/gmii_rx.sv */
`timescale 1ns/1ps

module gmii_rx
    import mac_frame_pkg::*, mac_buffer_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  byte_t     gmii_rxd,
    input  logic      gmii_rx_dv,
    input  logic      gmii_rx_er,
    output logic      wr_en,
    output pkt_addr_t wr_addr,
    output byte_t     wr_data,
    output logic      commit,
    output pkt_len_t  commit_len,
    input  logic      full
);

    typedef enum logic [1:0] {st_idle, st_preamble, st_payload, st_drop} rx_state_t;

    localparam int max_frame_bytes = max_packet_bytes + fcs_len;

    rx_state_t   state;
    pkt_len_t    cnt;       // preamble bytes, then payload plus fcs bytes
    logic [31:0] crc;
    logic [31:0] crc_msb;
    logic        crc_ok;

    assign crc_msb = {<<{crc}};   // residue constant is msb-first
    assign crc_ok  = (crc_msb == crc_residue) && (cnt >= pkt_len_t'(fcs_len));

    always_ff @(posedge clock) begin
        wr_addr <= cnt;
        wr_data <= gmii_rxd;
        if (state == st_preamble) begin
            crc <= crc_init;
        end else if (state == st_payload && gmii_rx_dv) begin
            crc        <= crc32_next(crc, gmii_rxd);
        end
        if (state == st_payload) begin
            commit_len <= cnt - pkt_len_t'(fcs_len);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state  <= st_idle;
            cnt    <= '0;
            wr_en  <= 1'b0;
            commit <= 1'b0;
        end else begin
            wr_en  <= 1'b0;
            commit <= 1'b0;
            case (state)
                st_idle: begin
                    if (gmii_rx_dv && !gmii_rx_er && gmii_rxd == preamble_byte) begin
                        state <= st_preamble;
                        cnt   <= pkt_len_t'(1);
                    end else if (gmii_rx_dv) begin
                        state <= st_drop;
                    end
                end
                st_preamble: begin
                    if (!gmii_rx_dv) begin
                        state <= st_idle;   // runt
                    end else if (gmii_rx_er) begin
                        state <= st_drop;
                    end else if (cnt < pkt_len_t'(preamble_len)) begin
                        if (gmii_rxd == preamble_byte) begin
                            cnt <= cnt + 1'b1;
                        end else begin
                            state <= st_drop;
                        end
                    end else if (gmii_rxd == sfd_byte && !full) begin
                        state <= st_payload;
                        cnt   <= '0;
                    end else begin
                        state <= st_drop;
                    end
                end
                st_payload: begin
                    if (!gmii_rx_dv) begin
                        commit <= crc_ok && !full;
                        state  <= st_idle;
                    end else if (gmii_rx_er || cnt == pkt_len_t'(max_frame_bytes)) begin
                        state <= st_drop;
                    end else begin
                        wr_en <= (cnt < pkt_len_t'(max_packet_bytes)); // fcs tail not kept
                        cnt   <= cnt + 1'b1;
                    end
                end
                st_drop: begin
                    if (!gmii_rx_dv) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* design/eth_mac_top.sv */
`timescale 1ns/1ps

module eth_mac_top
    import mac_frame_pkg::*, mac_buffer_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      start,
    input  host_op_t  op,
    input  pkt_addr_t address,
    input  byte_t     value,
    output logic      done,
    output result_t   result,
    output byte_t     gmii_txd,
    output logic      gmii_tx_en,
    input  byte_t     gmii_rxd,
    input  logic      gmii_rx_dv,
    input  logic      gmii_rx_er
);

    // transmit ring, host writes and framer drains
    logic      tx_wr_en;
    pkt_addr_t tx_wr_addr;
    byte_t     tx_wr_data;
    logic      tx_commit;
    pkt_len_t  tx_commit_len;
    logic      tx_full;
    pkt_addr_t tx_rd_addr;
    byte_t     tx_rd_data;
    pkt_len_t  tx_rd_len;
    logic      tx_release;
    logic      tx_empty;

    // receive ring, deframer fills and host reads
    logic      rx_wr_en;
    pkt_addr_t rx_wr_addr;
    byte_t     rx_wr_data;
    logic      rx_commit;
    pkt_len_t  rx_commit_len;
    logic      rx_full;
    pkt_addr_t rx_rd_addr;
    byte_t     rx_rd_data;
    pkt_len_t  rx_rd_len;
    logic      rx_release;
    logic      rx_empty;

    // ----------------------------------------
    host_ops i_host_ops (
        .clock, .reset, .start, .op, .address, .value, .done, .result,
        .tx_wr_en, .tx_wr_addr, .tx_wr_data, .tx_commit, .tx_commit_len, .tx_full,
        .rx_rd_addr, .rx_rd_data, .rx_rd_len, .rx_empty, .rx_release
    );

    packet_ring tx_ring (
        .clock, .reset,
        .wr_en(tx_wr_en), .wr_addr(tx_wr_addr), .wr_data(tx_wr_data),
        .commit(tx_commit), .commit_len(tx_commit_len), .full(tx_full),
        .rd_addr(tx_rd_addr), .rd_data(tx_rd_data), .rd_len(tx_rd_len),
        .release_pkt(tx_release), .empty(tx_empty)
    );

    packet_ring rx_ring (
        .clock, .reset,
        .wr_en(rx_wr_en), .wr_addr(rx_wr_addr), .wr_data(rx_wr_data),
        .commit(rx_commit), .commit_len(rx_commit_len), .full(rx_full),
        .rd_addr(rx_rd_addr), .rd_data(rx_rd_data), .rd_len(rx_rd_len),
        .release_pkt(rx_release), .empty(rx_empty)
    );

    // ----------------------------------------
    gmii_tx i_gmii_tx (
        .clock, .reset,
        .rd_addr(tx_rd_addr), .rd_data(tx_rd_data), .rd_len(tx_rd_len),
        .empty(tx_empty), .release_pkt(tx_release),
        .gmii_txd, .gmii_tx_en
    );

    gmii_rx i_gmii_rx (
        .clock, .reset,
        .gmii_rxd, .gmii_rx_dv, .gmii_rx_er,
        .wr_en(rx_wr_en), .wr_addr(rx_wr_addr), .wr_data(rx_wr_data),
        .commit(rx_commit), .commit_len(rx_commit_len), .full(rx_full)
    );

endmodule

/* bench/eth_mac_properties.sv */
`timescale 1ns/1ps

module eth_mac_properties
    import mac_frame_pkg::*, mac_buffer_pkg::*;
(
    input logic     clock,
    input logic     reset,
    input logic     start,
    input logic     done,
    input logic     gmii_tx_en,
    input pkt_len_t tx_rd_len,
    input logic     tx_commit,
    input logic     tx_full,
    input logic     tx_release,
    input logic     tx_empty,
    input logic     rx_commit,
    input logic     rx_full,
    input logic     rx_release,
    input logic     rx_empty
);

    int en_run;     // tx_en high cycles in this frame
    int low_run;    // tx_en low cycles since the last frame
    int frame_len;  // payload length of the frame on the wire
    int tx_used;    // packets held in the transmit ring
    int rx_used;    // packets held in the receive ring

    always_ff @(posedge clock) begin
        if (reset) begin
            en_run    <= 0;
            low_run   <= ifg_cycles;   // reset counts as idle line
            frame_len <= 0;
        end else if (gmii_tx_en) begin
            if (en_run == 0) begin
                frame_len <= int'(tx_rd_len);
            end
            en_run  <= en_run + 1;
            low_run <= 0;
        end else begin
            en_run <= 0;
            if (low_run < ifg_cycles) begin
                low_run <= low_run + 1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            tx_used <= 0;
            rx_used <= 0;
        end else begin
            tx_used <= tx_used + int'(tx_commit) - int'(tx_release);
            rx_used <= rx_used + int'(rx_commit) - int'(rx_release);
        end
    end

    // ----------------------------------------
    // host handshake
    // ----------------------------------------
    // done rises on the second edge after start and shows in the third sample
    done_timing: assert property (@(posedge clock) disable iff (reset)
        done == $past(start, 3))
        else $error("done not exactly two edges after an accepted start");

    // ----------------------------------------
    // ring use
    // ----------------------------------------
    tx_commit_room: assert property (@(posedge clock) disable iff (reset)
        tx_commit |-> tx_used < ring_depth)
        else $error("commit on a full transmit ring");

    rx_commit_room: assert property (@(posedge clock) disable iff (reset)
        rx_commit |-> rx_used < ring_depth)
        else $error("commit on a full receive ring");

    tx_release_used: assert property (@(posedge clock) disable iff (reset)
        tx_release |-> tx_used > 0)
        else $error("release on an empty transmit ring");

    rx_release_used: assert property (@(posedge clock) disable iff (reset)
        rx_release |-> rx_used > 0)
        else $error("release on an empty receive ring");

    tx_flags: assert property (@(posedge clock) disable iff (reset)
        tx_full == (tx_used == ring_depth) && tx_empty == (tx_used == 0))
        else $error("transmit ring full or empty flag disagrees with its packet count");

    rx_flags: assert property (@(posedge clock) disable iff (reset)
        rx_full == (rx_used == ring_depth) && rx_empty == (rx_used == 0))
        else $error("receive ring full or empty flag disagrees with its packet count");

    // ----------------------------------------
    // gmii framing
    // ----------------------------------------
    frame_length: assert property (@(posedge clock) disable iff (reset)
        $fell(gmii_tx_en) |-> en_run == preamble_len + 1 + frame_len + fcs_len)
        else $error("tx_en high time does not match the packet length");

    frame_gap: assert property (@(posedge clock) disable iff (reset)
        $rose(gmii_tx_en) |-> low_run >= ifg_cycles)
        else $error("interframe gap too short");

endmodule

bind eth_mac_top eth_mac_properties i_eth_mac_properties (
    .clock(clock),
    .reset(reset),
    .start(start),
    .done(done),
    .gmii_tx_en(gmii_tx_en),
    .tx_rd_len(tx_rd_len),
    .tx_commit(tx_commit),
    .tx_full(tx_full),
    .tx_release(tx_release),
    .tx_empty(tx_empty),
    .rx_commit(rx_commit),
    .rx_full(rx_full),
    .rx_release(rx_release),
    .rx_empty(rx_empty)
);

/* bench/eth_mac_tb.sv */
`timescale 1ns/1ps

module eth_mac_tb
    import mac_frame_pkg::*, mac_buffer_pkg::*;
();

    localparam int op_timeout    = 20;
    localparam int frame_timeout = 400;
    localparam int drain_timeout = 4000;

    logic      clock;
    logic      reset;
    logic      start;
    host_op_t  op;
    pkt_addr_t address;
    byte_t     value;
    logic      done;
    result_t   result;
    byte_t     gmii_txd;
    logic      gmii_tx_en;
    byte_t     gmii_rxd;
    logic      gmii_rx_dv;
    logic      gmii_rx_er;

    logic      loopback;
    byte_t     frame_rxd;   // testbench-built receive frame
    logic      frame_dv;
    logic      frame_er;

    int        errors = 0;
    int        checks = 0;
    int        frames_seen = 0;
    logic      tx_en_q = 1'b0;
    byte_t     tx_bytes[$];
    byte_t     payload[$];

    assign gmii_rxd   = loopback ? gmii_txd : frame_rxd;
    assign gmii_rx_dv = loopback ? gmii_tx_en : frame_dv;
    assign gmii_rx_er = loopback ? 1'b0 : frame_er;

    eth_mac_top i_eth_mac_top (
        .clock, .reset, .start, .op, .address, .value, .done, .result,
        .gmii_txd, .gmii_tx_en, .gmii_rxd, .gmii_rx_dv, .gmii_rx_er
    );

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    // transmit capture, mid-cycle
    always @(negedge clock) begin
        if (gmii_tx_en === 1'b1) begin
            tx_bytes.push_back(gmii_txd);
            if (!tx_en_q) begin
                frames_seen++;
            end
        end
        tx_en_q = (gmii_tx_en === 1'b1);
    end

    // ----------------------------------------
    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
        finish_run();
    endtask

    task automatic expect_equal(input string name, input int expected, input int actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("[ERROR] %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
        end
    endtask

    // bit-serial ieee 802.3 crc over the payload, complemented
    function automatic logic [31:0] payload_fcs();
        logic [31:0] r;
        logic        fb;
        r = 32'hffff_ffff;
        foreach (payload[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = r[0] ^ payload[i][b];
                r  = r >> 1;
                if (fb) begin
                    r = r ^ 32'hedb8_8320;
                end
            end
        end
        return ~r;
    endfunction

    task automatic make_payload(input int n);
        payload.delete();
        for (int i = 0; i < n; i++) begin
            payload.push_back(byte_t'($urandom));
        end
    endtask

    // called on a falling edge, start goes out at once
    task automatic run_host_op(input host_op_t o, input int addr, input int val, output int res);
        int n;
        start   = 1'b1;
        op      = o;
        address = pkt_addr_t'(addr);
        value   = byte_t'(val);
        @(negedge clock);
        start = 1'b0;
        n = 0;
        while (done !== 1'b1) begin
            if (n == op_timeout) begin
                give_up("done on the host port");
            end
            @(negedge clock);
            n++;
        end
        res = int'(result);
    endtask

    task automatic op_expect(input host_op_t o, input int addr, input int val, input int expected);
        int res;
        run_host_op(o, addr, val, res);
        expect_equal($sformatf("result of %s at %0d", o.name(), addr), expected, res);
    endtask

    task automatic wait_tx_en(input logic level);
        int n;
        n = 0;
        while (gmii_tx_en !== level) begin
            if (n == frame_timeout) begin
                give_up("a change on gmii_tx_en");
            end
            @(negedge clock);
            n++;
        end
    endtask

    task automatic check_tx_frame();
        logic [31:0] fcs;
        int          base;
        fcs  = payload_fcs();
        base = preamble_len + 1;
        expect_equal("gmii_tx_en cycles", base + payload.size() + fcs_len, tx_bytes.size());
        for (int i = 0; i < preamble_len; i++) begin
            expect_equal("gmii_txd preamble", int'(preamble_byte), int'(tx_bytes[i]));
        end
        expect_equal("gmii_txd sfd", int'(sfd_byte), int'(tx_bytes[preamble_len]));
        foreach (payload[i]) begin
            expect_equal("gmii_txd payload", int'(payload[i]), int'(tx_bytes[base + i]));
        end
        for (int i = 0; i < fcs_len; i++) begin
            expect_equal("gmii_txd fcs", int'(fcs[8*i +: 8]),
                         int'(tx_bytes[base + payload.size() + i]));
        end
    endtask

    // flip_at flips one payload byte, er_at raises rx_er on one frame byte
    task automatic send_frame(input int flip_at, input int er_at);
        byte_t       bytes[$];
        logic [31:0] fcs;
        fcs = payload_fcs();
        for (int i = 0; i < preamble_len; i++) begin
            bytes.push_back(preamble_byte);
        end
        bytes.push_back(sfd_byte);
        foreach (payload[i]) begin
            bytes.push_back((i == flip_at) ? ~payload[i] : payload[i]);
        end
        for (int i = 0; i < fcs_len; i++) begin
            bytes.push_back(fcs[8*i +: 8]);
        end
        foreach (bytes[i]) begin
            frame_rxd = bytes[i];
            frame_dv  = 1'b1;
            frame_er  = (i == er_at);
            @(negedge clock);
        end
        frame_rxd = '0;
        frame_dv  = 1'b0;
        frame_er  = 1'b0;
        repeat (3) @(negedge clock);   // commit lands within two cycles
    endtask

    // ----------------------------------------
    initial begin
        int n;
        int res;
        int attempts;
        int commits_ok;
        int frames_base;
        reset     = 1'b1;
        start     = 1'b0;
        op        = op_read;
        address   = '0;
        value     = '0;
        loopback  = 1'b0;
        frame_rxd = '0;
        frame_dv  = 1'b0;
        frame_er  = 1'b0;
        void'($urandom(32'h19bb_d781));
        repeat (8) @(negedge clock);
        reset = 1'b0;

        // idle state after reset
        expect_equal("done", 0, int'(done));
        expect_equal("gmii_tx_en", 0, int'(gmii_tx_en));
        op_expect(op_read_len, 0, 0, 0);
        op_expect(op_read_next, 0, 0, 1);

        // fill a transmit packet, highest address first
        n = 20 + int'($urandom % 45);
        make_payload(n);
        op_expect(op_write, max_packet_bytes, 8'h5a, 1);
        for (int i = n - 1; i >= 0; i--) begin
            op_expect(op_write, i, int'(payload[i]), 0);
        end
        op_expect(op_write_len, 0, 0, n);

        // send it through the loopback
        loopback = 1'b1;
        tx_bytes.delete();
        op_expect(op_write_next, 0, 0, 0);
        wait_tx_en(1'b1);
        wait_tx_en(1'b0);
        check_tx_frame();
        repeat (3) @(negedge clock);
        op_expect(op_read_len, 0, 0, n);
        foreach (payload[i]) begin
            op_expect(op_read, i, 0, int'(payload[i]));
        end
        op_expect(op_read, n, 0, 0);
        op_expect(op_read_next, 0, 0, 0);
        op_expect(op_read_next, 0, 0, 1);

        // ----------------------------------------
        // bad frames are dropped, a good one is kept
        loopback = 1'b0;
        make_payload(12);
        send_frame(5, -1);
        op_expect(op_read_len, 0, 0, 0);
        send_frame(-1, preamble_len + 2);
        op_expect(op_read_len, 0, 0, 0);
        send_frame(-1, -1);
        op_expect(op_read_len, 0, 0, 12);
        op_expect(op_read_next, 0, 0, 0);

        // one-byte packets back to back until the ring fills
        frames_base = frames_seen;
        commits_ok  = 0;
        attempts    = 0;
        res         = 0;
        while (res == 0 && attempts < ring_depth + 3) begin
            op_expect(op_write, 0, int'($urandom % 256), 0);
            run_host_op(op_write_next, 0, 0, res);
            attempts++;
            if (res == 0) begin
                commits_ok++;
            end
        end
        expect_equal("op_write_next full flag", 1, res);
        n = 0;
        while (gmii_tx_en !== 1'b0 || i_eth_mac_top.tx_empty !== 1'b1) begin
            if (n == drain_timeout) begin
                give_up("the transmit ring to drain");
            end
            @(negedge clock);
            n++;
        end
        expect_equal("frames on gmii_tx_en", commits_ok, frames_seen - frames_base);
        finish_run();
    end

endmodule

/* sources.f */
design/mac_frame_pkg.sv
design/mac_buffer_pkg.sv
design/packet_ring.sv
design/host_ops.sv
design/gmii_tx.sv
design/gmii_rx.sv
design/eth_mac_top.sv
bench/eth_mac_properties.sv
bench/eth_mac_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with verilator, result taken from the log

cd "$(dirname "$0")" || exit 1
log=sim.log

if ! verilator --binary --timing --assert --top-module eth_mac_tb -f sources.f -o eth_mac_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/eth_mac_sim > "$log" 2>&1; then
    cat "$log"
    echo "simulation exited with an error"
    exit 1
fi

cat "$log"
if grep -q "All tests passed" "$log"; then
    exit 0
fi
exit 1
